/* execStage.f */
+incdir+hdl
hdl/execPkg.sv
hdl/exDecode.sv
hdl/forwardUnit.sv
hdl/alu.sv
hdl/execute.sv
hdl/execTop.sv
sim/execTb.sv

/* hdl/alu.sv */
// ========================================
// 16-bit ALU of the execute stage
// Optional input inversion and carry-in feed
// the adder; shifts and rotates use the low
// four bits of inB. Flags follow the adder.
// ========================================

`timescale 1ns/1ps

`include "execStage_cfg.svh"

module alu (
    input  logic [`EXEC_DATA_W-1:0] inA,
    input  logic [`EXEC_DATA_W-1:0] inB,
    input  logic                    cIn,
    input  logic                    invA,
    input  logic                    invB,
    input  execPkg::aluOperT        oper,
    output logic [`EXEC_DATA_W-1:0] out,
    output logic                    zero,
    output logic                    ltz,
    output logic                    carry,
    output logic                    ofl
);

    logic [`EXEC_DATA_W-1:0]   opA;
    logic [`EXEC_DATA_W-1:0]   opB;
    logic [`EXEC_DATA_W-1:0]   sum;
    logic [3:0]                shAmt;
    logic [2*`EXEC_DATA_W-1:0] rolWide;
    logic [2*`EXEC_DATA_W-1:0] rorWide;

    assign opA = invA ? ~inA : inA;
    assign opB = invB ? ~inB : inB;

    assign {carry, sum} = {1'b0, opA} + {1'b0, opB} + {{`EXEC_DATA_W{1'b0}}, cIn};

    // Same operand signs but a different result sign
    assign ofl = (opA[`EXEC_DATA_W-1] == opB[`EXEC_DATA_W-1]) &&
                 (sum[`EXEC_DATA_W-1] != opA[`EXEC_DATA_W-1]);

    assign zero = (sum == '0);
    assign ltz = sum[`EXEC_DATA_W-1];

    assign shAmt = opB[3:0];

    // Rotates by shifting a doubled copy of the word
    assign rolWide = {opA, opA} << shAmt;
    assign rorWide = {opA, opA} >> shAmt;

    always_comb begin
        case (oper)
            execPkg::OPER_ROL: out = rolWide[2*`EXEC_DATA_W-1:`EXEC_DATA_W];
            execPkg::OPER_SLL: out = opA << shAmt;
            execPkg::OPER_ROR: out = rorWide[`EXEC_DATA_W-1:0];
            execPkg::OPER_SRL: out = opA >> shAmt;
            execPkg::OPER_ADD: out = sum;
            execPkg::OPER_AND: out = opA & opB;
            execPkg::OPER_OR:  out = opA | opB;
            default:           out = opA ^ opB;
        endcase
    end

    always_comb begin
        assert final ($isunknown({inA, inB, cIn, invA, invB, oper}) || !$isunknown(out))
            else $error("alu: unknown output from known inputs");
    end

endmodule

/* hdl/exDecode.sv */
// ========================================
// Opcode decoder for the execute stage
// Turns one instruction word into ALU
// controls, a destination register and the
// extended immediate. Purely combinational.
// ========================================

`timescale 1ns/1ps

`include "execStage_cfg.svh"

module exDecode (
    input  execPkg::instrWordT       instr,
    output execPkg::exCtrlT          ctrl,
    output logic [`EXEC_REG_W-1:0]   destReg,
    output logic [`EXEC_DATA_W-1:0]  immVal
);

    logic [4:0] imm5;
    logic [7:0] imm8;

    assign imm5 = instr.i1Fmt.imm5;
    assign imm8 = instr.i2Fmt.imm8;

    always_comb begin
        ctrl = '0;
        ctrl.aluOper = execPkg::OPER_OR;
        ctrl.writesReg = 1'b1;
        destReg = instr.rFmt.rd;
        immVal = {{(`EXEC_DATA_W-5){1'b0}}, imm5};

        case (instr.rFmt.opcode)
            execPkg::ALU_ARITH: begin
                case (instr.rFmt.func)
                    2'b00: ctrl.aluOper = execPkg::OPER_ADD;
                    2'b01: begin
                        // Rt - Rs as ~Rs + Rt + 1
                        ctrl.aluOper = execPkg::OPER_ADD;
                        ctrl.invA = 1'b1;
                        ctrl.cIn = 1'b1;
                    end
                    2'b10: ctrl.aluOper = execPkg::OPER_XOR;
                    default: begin
                        ctrl.aluOper = execPkg::OPER_AND;
                        ctrl.invB = 1'b1;
                    end
                endcase
            end
            execPkg::ALU_SHIFT: begin
                case (instr.rFmt.func)
                    2'b00: ctrl.aluOper = execPkg::OPER_ROL;
                    2'b01: ctrl.aluOper = execPkg::OPER_SLL;
                    2'b10: ctrl.aluOper = execPkg::OPER_ROR;
                    default: ctrl.aluOper = execPkg::OPER_SRL;
                endcase
            end
            execPkg::ADDI, execPkg::SUBI: begin
                ctrl.aluOper = execPkg::OPER_ADD;
                ctrl.useImm = 1'b1;
                ctrl.invA = (instr.i1Fmt.opcode == execPkg::SUBI);
                ctrl.cIn = (instr.i1Fmt.opcode == execPkg::SUBI);
                destReg = instr.i1Fmt.rd;
                immVal = {{(`EXEC_DATA_W-5){imm5[4]}}, imm5};
            end
            execPkg::XORI: begin
                ctrl.aluOper = execPkg::OPER_XOR;
                ctrl.useImm = 1'b1;
                destReg = instr.i1Fmt.rd;
            end
            execPkg::ANDNI: begin
                ctrl.aluOper = execPkg::OPER_AND;
                ctrl.invB = 1'b1;
                ctrl.useImm = 1'b1;
                destReg = instr.i1Fmt.rd;
            end
            execPkg::ROLI, execPkg::SLLI, execPkg::RORI, execPkg::SRLI: begin
                // Low two opcode bits follow the ALU shift order
                ctrl.aluOper = execPkg::aluOperT'({1'b0, instr.i1Fmt.opcode[1:0]});
                ctrl.useImm = 1'b1;
                destReg = instr.i1Fmt.rd;
            end
            execPkg::LBI: begin
                ctrl.isLbi = 1'b1;
                destReg = instr.i2Fmt.rs;
                immVal = {{(`EXEC_DATA_W-8){imm8[7]}}, imm8};
            end
            execPkg::SLBI: begin
                ctrl.isSlbi = 1'b1;
                destReg = instr.i2Fmt.rs;
                immVal = {{(`EXEC_DATA_W-8){1'b0}}, imm8};
            end
            execPkg::BTR: ctrl.isBtr = 1'b1;
            execPkg::SEQ, execPkg::SLT, execPkg::SLE, execPkg::SCO: begin
                ctrl.aluOper = execPkg::OPER_ADD;
                ctrl.isSet = 1'b1;
                ctrl.setCond = execPkg::setCondT'(instr.rFmt.opcode[1:0]);
                // Rs - Rt, except SCO which wants the plain sum
                ctrl.invB = (instr.rFmt.opcode != execPkg::SCO);
                ctrl.cIn = (instr.rFmt.opcode != execPkg::SCO);
            end
            default: ctrl.writesReg = 1'b0;
        endcase
    end

endmodule

/* hdl/execPkg.sv */
// ========================================
// Types shared by the execute stage
// Instruction word views, opcodes, ALU and
// set-condition codes, forwarding bundles
// and the EX/MEM register layout.
// ========================================

`include "execStage_cfg.svh"

package execPkg;

    typedef enum logic [`EXEC_OP_W-1:0] {
        ADDI      = 5'b01000,
        SUBI      = 5'b01001,
        XORI      = 5'b01010,
        ANDNI     = 5'b01011,
        ROLI      = 5'b10100,
        SLLI      = 5'b10101,
        RORI      = 5'b10110,
        SRLI      = 5'b10111,
        SLBI      = 5'b10010,
        LBI       = 5'b11000,
        BTR       = 5'b11001,
        ALU_SHIFT = 5'b11010,
        ALU_ARITH = 5'b11011,
        SEQ       = 5'b11100,
        SLT       = 5'b11101,
        SLE       = 5'b11110,
        SCO       = 5'b11111
    } opcodeT;

    // Same 16 bits seen as R, I1 or I2 format
    typedef union packed {
        struct packed {
            opcodeT                 opcode;
            logic [`EXEC_REG_W-1:0] rs;
            logic [`EXEC_REG_W-1:0] rt;
            logic [`EXEC_REG_W-1:0] rd;
            logic [1:0]             func;
        } rFmt;
        struct packed {
            opcodeT                 opcode;
            logic [`EXEC_REG_W-1:0] rs;
            logic [`EXEC_REG_W-1:0] rd;
            logic [4:0]             imm5;
        } i1Fmt;
        struct packed {
            opcodeT                 opcode;
            logic [`EXEC_REG_W-1:0] rs;
            logic [7:0]             imm8;
        } i2Fmt;
    } instrWordT;

    typedef enum logic [2:0] {
        OPER_ROL = 3'd0,
        OPER_SLL = 3'd1,
        OPER_ROR = 3'd2,
        OPER_SRL = 3'd3,
        OPER_ADD = 3'd4,
        OPER_AND = 3'd5,
        OPER_OR  = 3'd6,
        OPER_XOR = 3'd7
    } aluOperT;

    typedef enum logic [1:0] {
        SET_EQ = 2'd0,
        SET_LT = 2'd1,
        SET_LE = 2'd2,
        SET_CO = 2'd3
    } setCondT;

    typedef struct packed {
        aluOperT aluOper;
        logic    invA;
        logic    invB;
        logic    cIn;
        logic    useImm;
        logic    isSet;
        setCondT setCond;
        logic    isBtr;
        logic    isLbi;
        logic    isSlbi;
        logic    writesReg;
    } exCtrlT;

    // Result bus of a later stage, offered for forwarding
    typedef struct packed {
        logic                    writesReg;
        logic                    isLoad;
        logic [`EXEC_REG_W-1:0]  destReg;
        logic [`EXEC_DATA_W-1:0] aluRes;
        logic [`EXEC_DATA_W-1:0] memData;
    } fwdSrcT;

    typedef enum logic [1:0] {
        FWD_REG_FILE   = 2'd0,
        FWD_EX_MEM     = 2'd1,
        FWD_MEM_WB_ALU = 2'd2,
        FWD_MEM_WB_MEM = 2'd3
    } fwdSelT;

    typedef struct packed {
        logic                    valid;
        logic                    writesReg;
        logic [`EXEC_REG_W-1:0]  destReg;
        logic [`EXEC_DATA_W-1:0] result;
        logic                    zero;
        logic                    ltz;
        logic                    err;
    } exMemT;

endpackage

/* hdl/execStage_cfg.svh */
// ========================================
// Fixed sizes of the execute stage
// Data width, register numbers and opcode
// width come from the instruction set.
// Include this header wherever these are needed.
// ========================================

`ifndef EXEC_STAGE_CFG_SVH
`define EXEC_STAGE_CFG_SVH

`define EXEC_DATA_W 16
`define EXEC_REG_W 3
`define EXEC_OP_W 5

// Result held by the EX/MEM register out of reset
`define EXEC_RESULT_RESET 16'h0000

`endif

/* hdl/execTop.sv */
// ========================================
// Execute stage top level
// Decode, forwarding and execute settle in one
// cycle; the EX/MEM register captures the
// result at the next clock edge.
// ========================================

`timescale 1ns/1ps

`include "execStage_cfg.svh"

module execTop (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    inValid,
    input  execPkg::instrWordT      instr,
    input  logic [`EXEC_DATA_W-1:0] rsData,
    input  logic [`EXEC_DATA_W-1:0] rtData,
    input  execPkg::fwdSrcT         exMemFwd,
    input  execPkg::fwdSrcT         memWbFwd,
    output execPkg::exMemT          exMemOut
);

    execPkg::exCtrlT         ctrl;
    logic [`EXEC_REG_W-1:0]  destReg;
    logic [`EXEC_DATA_W-1:0] immVal;
    execPkg::fwdSelT         selA;
    execPkg::fwdSelT         selB;
    logic [`EXEC_DATA_W-1:0] result;
    logic                    zero;
    logic                    ltz;
    logic                    err;

    exDecode decodeInst (
        .instr   (instr),
        .ctrl    (ctrl),
        .destReg (destReg),
        .immVal  (immVal)
    );

    // Source numbers sit at the same bits in every format
    forwardUnit fwdInst (
        .rsReg    (instr.rFmt.rs),
        .rtReg    (instr.rFmt.rt),
        .exMemFwd (exMemFwd),
        .memWbFwd (memWbFwd),
        .selA     (selA),
        .selB     (selB)
    );

    execute executeInst (
        .ctrl     (ctrl),
        .immVal   (immVal),
        .rsData   (rsData),
        .rtData   (rtData),
        .selA     (selA),
        .selB     (selB),
        .exMemFwd (exMemFwd),
        .memWbFwd (memWbFwd),
        .result   (result),
        .zero     (zero),
        .ltz      (ltz),
        .err      (err)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            exMemOut.valid <= 1'b0;
            exMemOut.writesReg <= 1'b0;
            exMemOut.err <= 1'b0;
            exMemOut.result <= `EXEC_RESULT_RESET;
        end else begin
            exMemOut.valid <= inValid;
            exMemOut.writesReg <= inValid & ctrl.writesReg;
            exMemOut.err <= inValid & err;
            exMemOut.result <= result;
        end
        exMemOut.destReg <= destReg;
        exMemOut.zero <= zero;
        exMemOut.ltz <= ltz;
    end

    assert property (@(posedge clk) rst |=> !exMemOut.valid)
        else $error("execTop: EX/MEM valid set right after reset");

endmodule

/* hdl/execute.sv */
// ========================================
// Combinational execute datapath
// Picks the forwarded operands, runs the ALU
// and forms the final result for set, BTR,
// LBI and SLBI, plus the overflow error.
// ========================================

`timescale 1ns/1ps

`include "execStage_cfg.svh"

module execute (
    input  execPkg::exCtrlT         ctrl,
    input  logic [`EXEC_DATA_W-1:0] immVal,
    input  logic [`EXEC_DATA_W-1:0] rsData,
    input  logic [`EXEC_DATA_W-1:0] rtData,
    input  execPkg::fwdSelT         selA,
    input  execPkg::fwdSelT         selB,
    input  execPkg::fwdSrcT         exMemFwd,
    input  execPkg::fwdSrcT         memWbFwd,
    output logic [`EXEC_DATA_W-1:0] result,
    output logic                    zero,
    output logic                    ltz,
    output logic                    err
);

    logic [`EXEC_DATA_W-1:0] rsVal;
    logic [`EXEC_DATA_W-1:0] rtVal;
    logic [`EXEC_DATA_W-1:0] aluB;
    logic [`EXEC_DATA_W-1:0] aluOut;
    logic [`EXEC_DATA_W-1:0] btrVal;
    logic                    carry;
    logic                    ofl;
    logic                    setBit;

    function automatic logic [`EXEC_DATA_W-1:0] pickOperand(
        input execPkg::fwdSelT         sel,
        input logic [`EXEC_DATA_W-1:0] rfVal,
        input execPkg::fwdSrcT         exMem,
        input execPkg::fwdSrcT         memWb
    );
        case (sel)
            execPkg::FWD_EX_MEM:     return exMem.aluRes;
            execPkg::FWD_MEM_WB_ALU: return memWb.aluRes;
            execPkg::FWD_MEM_WB_MEM: return memWb.memData;
            default:                 return rfVal;
        endcase
    endfunction

    assign rsVal = pickOperand(selA, rsData, exMemFwd, memWbFwd);
    assign rtVal = pickOperand(selB, rtData, exMemFwd, memWbFwd);
    assign aluB = ctrl.useImm ? immVal : rtVal;

    alu aluInst (
        .inA   (rsVal),
        .inB   (aluB),
        .cIn   (ctrl.cIn),
        .invA  (ctrl.invA),
        .invB  (ctrl.invB),
        .oper  (ctrl.aluOper),
        .out   (aluOut),
        .zero  (zero),
        .ltz   (ltz),
        .carry (carry),
        .ofl   (ofl)
    );

    assign btrVal = {<<{rsVal}};

    always_comb begin
        case (ctrl.setCond)
            execPkg::SET_EQ: setBit = zero;
            execPkg::SET_LT: setBit = ltz;
            execPkg::SET_LE: setBit = zero | ltz;
            default:         setBit = carry;
        endcase
    end

    always_comb begin
        if (ctrl.isLbi) begin
            result = immVal;
        end else if (ctrl.isSlbi) begin
            result = (rsVal << 8) | immVal;
        end else if (ctrl.isBtr) begin
            result = btrVal;
        end else if (ctrl.isSet) begin
            result = {{(`EXEC_DATA_W-1){1'b0}}, setBit};
        end else begin
            result = aluOut;
        end
    end

    // Set instructions also use the adder, so they are excluded here
    assign err = ofl && (ctrl.aluOper == execPkg::OPER_ADD) && !ctrl.isSet;

endmodule

/* hdl/forwardUnit.sv */
// ========================================
// Operand forwarding selection
// Compares both source registers against the
// EX/MEM and MEM/WB destinations and steers
// the operand muxes in execute.
// ========================================

`timescale 1ns/1ps

`include "execStage_cfg.svh"

module forwardUnit (
    input  logic [`EXEC_REG_W-1:0] rsReg,
    input  logic [`EXEC_REG_W-1:0] rtReg,
    input  execPkg::fwdSrcT        exMemFwd,
    input  execPkg::fwdSrcT        memWbFwd,
    output execPkg::fwdSelT        selA,
    output execPkg::fwdSelT        selB
);

    // Youngest matching writer wins; register 0 is not special
    function automatic execPkg::fwdSelT pickSrc(
        input logic [`EXEC_REG_W-1:0] srcReg,
        input execPkg::fwdSrcT        exMem,
        input execPkg::fwdSrcT        memWb
    );
        execPkg::fwdSelT sel;
        sel = execPkg::FWD_REG_FILE;
        if (exMem.writesReg && exMem.destReg == srcReg) begin
            sel = execPkg::FWD_EX_MEM;
        end else if (memWb.writesReg && memWb.destReg == srcReg) begin
            if (memWb.isLoad) begin
                sel = execPkg::FWD_MEM_WB_MEM;
            end else begin
                sel = execPkg::FWD_MEM_WB_ALU;
            end
        end
        return sel;
    endfunction

    assign selA = pickSrc(rsReg, exMemFwd, memWbFwd);
    assign selB = pickSrc(rtReg, exMemFwd, memWbFwd);

    // A load in EX/MEM has no data yet, so the pipeline must never need it here
    always_comb begin
        assert final (!(exMemFwd.isLoad &&
                        (selA == execPkg::FWD_EX_MEM || selB == execPkg::FWD_EX_MEM)))
            else $error("forwardUnit: operand taken from a load still in EX/MEM");
    end

endmodule

/* runSim.sh */
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it.
# Exits nonzero unless the run ends with the pass message.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f execStage.f --top-module execTb -Mdir obj_dir

out=$(./obj_dir/VexecTb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
    exit 0
else
    echo "Simulation did not pass"
    exit 1
fi

/* sim/execTb.sv */
// ========================================
// Directed testbench for the execute stage
// Drives execTop one instruction per cycle,
// predicts each EX/MEM entry from the ISA
// rules and checks it one cycle later.
// ========================================

`timescale 1ns/1ps

`include "execStage_cfg.svh"

module execTb;

    // About 130 cycles of tests; the limit leaves ample margin
    localparam int maxCycles = 2000;
    localparam execPkg::fwdSrcT noFwd = '0;

    logic                    clk;
    logic                    rst;
    logic                    inValid;
    execPkg::instrWordT      instr;
    logic [`EXEC_DATA_W-1:0] rsData;
    logic [`EXEC_DATA_W-1:0] rtData;
    execPkg::fwdSrcT         exMemFwd;
    execPkg::fwdSrcT         memWbFwd;
    execPkg::exMemT          exMemOut;

    int cycleCount = 0;
    int errorCount = 0;
    int testCount = 0;
    int testErrors = 0;

    // Expected EX/MEM entry of the instruction issued last cycle
    execPkg::exMemT pendExp;
    logic [15:0]    pendWord;
    logic           pendLive;

    execTop dut_i (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .instr    (instr),
        .rsData   (rsData),
        .rtData   (rtData),
        .exMemFwd (exMemFwd),
        .memWbFwd (memWbFwd),
        .exMemOut (exMemOut)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    initial begin
        wait (cycleCount >= maxCycles);
        $display("Timeout: tests did not finish within %0d cycles", maxCycles);
        $display("Done: errors found");
        $finish;
    end

    function automatic logic [15:0] rInstr(
        input execPkg::opcodeT op,
        input logic [2:0]      rs,
        input logic [2:0]      rt,
        input logic [2:0]      rd,
        input logic [1:0]      fn
    );
        return {op, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] i1Instr(
        input execPkg::opcodeT op,
        input logic [2:0]      rs,
        input logic [2:0]      rd,
        input logic [4:0]      imm5
    );
        return {op, rs, rd, imm5};
    endfunction

    function automatic logic [15:0] i2Instr(
        input execPkg::opcodeT op,
        input logic [2:0]      rs,
        input logic [7:0]      imm8
    );
        return {op, rs, imm8};
    endfunction

    function automatic execPkg::fwdSrcT makeFwd(
        input logic        writes,
        input logic        isLoad,
        input logic [2:0]  dest,
        input logic [15:0] aluRes,
        input logic [15:0] memData
    );
        execPkg::fwdSrcT f;
        f.writesReg = writes;
        f.isLoad = isLoad;
        f.destReg = dest;
        f.aluRes = aluRes;
        f.memData = memData;
        return f;
    endfunction

    function automatic int signedVal(input logic [15:0] v);
        return int'($signed(v));
    endfunction

    function automatic logic [15:0] reverseBits(input logic [15:0] v);
        logic [15:0] r;
        for (int i = 0; i < 16; i++) begin
            r[i] = v[15-i];
        end
        return r;
    endfunction

    // Kind 0 rotates left, 1 shifts left, 2 rotates right and 3 shifts right logically
    function automatic logic [15:0] shiftExpected(
        input logic [1:0]  kind,
        input logic [15:0] a,
        input logic [3:0]  amt
    );
        case (kind)
            2'b00: return (a << amt) | (a >> (5'd16 - amt));
            2'b01: return a << amt;
            2'b10: return (a >> amt) | (a << (5'd16 - amt));
            default: return a >> amt;
        endcase
    endfunction

    function automatic logic isAddSub(input logic [15:0] w);
        return (w[15:11] == execPkg::ALU_ARITH && !w[1]) ||
               w[15:11] == execPkg::ADDI || w[15:11] == execPkg::SUBI;
    endfunction

    // Forwarded operand with the youngest matching writer first
    function automatic logic [15:0] refOperand(
        input logic [2:0]      regNum,
        input logic [15:0]     rfVal,
        input execPkg::fwdSrcT exF,
        input execPkg::fwdSrcT memF
    );
        if (exF.writesReg && exF.destReg == regNum) begin
            return exF.aluRes;
        end else if (memF.writesReg && memF.destReg == regNum) begin
            return memF.isLoad ? memF.memData : memF.aluRes;
        end
        return rfVal;
    endfunction

    function automatic execPkg::exMemT expectedResult(
        input logic [15:0] w,
        input logic [15:0] a,
        input logic [15:0] b
    );
        execPkg::exMemT e;
        logic [15:0]    imm5s;
        logic [15:0]    imm5z;
        logic [15:0]    diff;
        logic [16:0]    sum17;
        int             wide;
        e = '0;
        e.valid = 1'b1;
        e.writesReg = 1'b1;
        e.destReg = w[4:2];
        imm5s = {{11{w[4]}}, w[4:0]};
        imm5z = {11'b0, w[4:0]};
        diff = a - b;
        sum17 = {1'b0, a} + {1'b0, b};
        wide = 0;
        case (w[15:11])
            execPkg::ALU_ARITH: begin
                case (w[1:0])
                    2'b00: wide = signedVal(a) + signedVal(b);
                    2'b01: wide = signedVal(b) - signedVal(a);
                    2'b10: e.result = a ^ b;
                    default: e.result = a & ~b;
                endcase
            end
            execPkg::ALU_SHIFT: e.result = shiftExpected(w[1:0], a, b[3:0]);
            execPkg::ADDI: wide = signedVal(a) + signedVal(imm5s);
            execPkg::SUBI: wide = signedVal(imm5s) - signedVal(a);
            execPkg::XORI: e.result = a ^ imm5z;
            execPkg::ANDNI: e.result = a & ~imm5z;
            execPkg::ROLI, execPkg::SLLI, execPkg::RORI, execPkg::SRLI: begin
                e.result = shiftExpected(w[12:11], a, w[3:0]);
            end
            execPkg::LBI: e.result = {{8{w[7]}}, w[7:0]};
            execPkg::SLBI: e.result = {a[7:0], w[7:0]};
            execPkg::BTR: e.result = reverseBits(a);
            execPkg::SEQ: e.result = {15'b0, diff == 16'h0};
            execPkg::SLT: e.result = {15'b0, diff[15]};
            execPkg::SLE: e.result = {15'b0, diff == 16'h0 || diff[15]};
            execPkg::SCO: e.result = {15'b0, sum17[16]};
            default: e.writesReg = 1'b0;
        endcase
        // I1 format writes rd, I2 format writes rs
        if (w[15:13] == 3'b010 || w[15:13] == 3'b101) begin
            e.destReg = w[7:5];
        end else if (w[15:11] == execPkg::LBI || w[15:11] == execPkg::SLBI) begin
            e.destReg = w[10:8];
        end
        if (isAddSub(w)) begin
            e.result = wide[15:0];
            e.err = (wide > 32767) || (wide < -32768);
            e.zero = (e.result == 16'h0);
            e.ltz = e.result[15];
        end
        return e;
    endfunction

    task automatic checkEq(input string name, input logic [15:0] expVal,
                           input logic [15:0] actVal);
        if (actVal !== expVal) begin
            errorCount++;
            testErrors++;
            $display("CHECK FAILED %s: expected 0x%h, got 0x%h", name, expVal, actVal);
        end
    endtask

    task automatic checkOutput();
        checkEq("exMemOut.valid", 16'(pendExp.valid), 16'(exMemOut.valid));
        checkEq("exMemOut.writesReg", 16'(pendExp.writesReg), 16'(exMemOut.writesReg));
        checkEq("exMemOut.err", 16'(pendExp.err), 16'(exMemOut.err));
        if (pendExp.valid) begin
            checkEq("exMemOut.destReg", 16'(pendExp.destReg), 16'(exMemOut.destReg));
            checkEq("exMemOut.result", pendExp.result, exMemOut.result);
            if (isAddSub(pendWord)) begin
                checkEq("exMemOut.zero", 16'(pendExp.zero), 16'(exMemOut.zero));
                checkEq("exMemOut.ltz", 16'(pendExp.ltz), 16'(exMemOut.ltz));
            end
        end
    endtask

    // Drives one cycle and checks the entry of the previous one
    task automatic issue(input logic v, input logic [15:0] w, input logic [15:0] rsD,
                         input logic [15:0] rtD, input execPkg::fwdSrcT exF,
                         input execPkg::fwdSrcT memF);
        logic [15:0] a;
        logic [15:0] b;
        @(posedge clk);
        inValid <= v;
        instr <= w;
        rsData <= rsD;
        rtData <= rtD;
        exMemFwd <= exF;
        memWbFwd <= memF;
        @(negedge clk);
        if (pendLive) begin
            checkOutput();
        end
        a = refOperand(w[10:8], rsD, exF, memF);
        b = refOperand(w[7:5], rtD, exF, memF);
        if (v) begin
            pendExp = expectedResult(w, a, b);
        end else begin
            pendExp = '0;
        end
        pendWord = w;
        pendLive = 1'b1;
    endtask

    task automatic sendR(input execPkg::opcodeT op, input logic [1:0] fn,
                         input logic [15:0] rsD, input logic [15:0] rtD);
        issue(1'b1, rInstr(op, 3'($urandom), 3'($urandom), 3'($urandom), fn),
              rsD, rtD, noFwd, noFwd);
    endtask

    task automatic sendI1(input execPkg::opcodeT op, input logic [4:0] imm5,
                          input logic [15:0] rsD);
        issue(1'b1, i1Instr(op, 3'($urandom), 3'($urandom), imm5), rsD, 16'h0, noFwd, noFwd);
    endtask

    task automatic idleCycle();
        issue(1'b0, 16'h0, 16'h0, 16'h0, noFwd, noFwd);
    endtask

    task automatic endTest(input string name);
        testCount++;
        if (testErrors == 0) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: FAILED with %0d errors", name, testErrors);
        end
        testErrors = 0;
    endtask

    task automatic testResetArith();
        @(negedge clk);
        checkEq("exMemOut.valid", 16'h0, 16'(exMemOut.valid));
        checkEq("exMemOut.writesReg", 16'h0, 16'(exMemOut.writesReg));
        checkEq("exMemOut.err", 16'h0, 16'(exMemOut.err));
        checkEq("exMemOut.result", `EXEC_RESULT_RESET, exMemOut.result);
        for (int i = 0; i < 12; i++) begin
            sendR(execPkg::ALU_ARITH, 2'(i), 16'($urandom), 16'($urandom));
        end
        idleCycle();
        endTest("reset and R-format arithmetic");
    endtask

    task automatic testImmediates();
        execPkg::opcodeT ops [4] = '{execPkg::ADDI, execPkg::SUBI,
                                     execPkg::XORI, execPkg::ANDNI};
        logic [4:0] imm5;
        for (int i = 0; i < 16; i++) begin
            imm5 = 5'($urandom);
            // Each opcode sees both signs of imm5
            imm5[4] = i[2];
            sendI1(ops[i % 4], imm5, 16'($urandom));
        end
        idleCycle();
        endTest("immediate arithmetic");
    endtask

    task automatic testShifts();
        execPkg::opcodeT ops [4] = '{execPkg::ROLI, execPkg::SLLI,
                                     execPkg::RORI, execPkg::SRLI};
        for (int i = 0; i < 12; i++) begin
            sendR(execPkg::ALU_SHIFT, 2'(i), 16'($urandom), 16'($urandom));
        end
        for (int i = 0; i < 12; i++) begin
            sendI1(ops[i % 4], 5'($urandom), 16'($urandom));
        end
        sendI1(execPkg::ROLI, 5'd0, 16'hb00d);
        sendI1(execPkg::RORI, 5'd15, 16'h8001);
        idleCycle();
        endTest("shifts and rotates");
    endtask

    task automatic testSetMisc();
        logic [15:0] v;
        v = 16'($urandom);
        sendR(execPkg::SEQ, 2'b00, v, v);
        sendR(execPkg::SEQ, 2'b00, 16'h0005, 16'h0009);
        sendR(execPkg::SLT, 2'b00, 16'h0005, 16'h0009);
        sendR(execPkg::SLT, 2'b00, 16'h0009, 16'h0005);
        sendR(execPkg::SLT, 2'b00, 16'hfff0, 16'h0003);
        sendR(execPkg::SLE, 2'b00, v, v);
        sendR(execPkg::SLE, 2'b00, 16'h0005, 16'h0009);
        sendR(execPkg::SLE, 2'b00, 16'h0009, 16'h0005);
        sendR(execPkg::SCO, 2'b00, 16'hffff, 16'h0001);
        sendR(execPkg::SCO, 2'b00, 16'h0001, 16'h0001);
        sendR(execPkg::SCO, 2'b00, 16'h8000, 16'h8000);
        sendR(execPkg::BTR, 2'b00, 16'h0001, 16'h0);
        sendR(execPkg::BTR, 2'b00, 16'($urandom), 16'h0);
        issue(1'b1, i2Instr(execPkg::LBI, 3'd4, 8'h85), 16'h0, 16'h0, noFwd, noFwd);
        issue(1'b1, i2Instr(execPkg::LBI, 3'd0, 8'h7a), 16'h0, 16'h0, noFwd, noFwd);
        issue(1'b1, i2Instr(execPkg::SLBI, 3'd6, 8'hc3), 16'($urandom), 16'h0,
              noFwd, noFwd);
        idleCycle();
        endTest("set conditions, BTR, LBI and SLBI");
    endtask

    task automatic testForwarding();
        execPkg::fwdSrcT exF;
        execPkg::fwdSrcT memF;
        logic [15:0]     w;
        // EX/MEM beats MEM/WB for the same register
        exF = makeFwd(1'b1, 1'b0, 3'd3, 16'h1111, 16'h0);
        memF = makeFwd(1'b1, 1'b0, 3'd3, 16'h2222, 16'h3333);
        w = rInstr(execPkg::ALU_ARITH, 3'd3, 3'd5, 3'd1, 2'b01);
        issue(1'b1, w, 16'haaaa, 16'h0101, exF, memF);
        // A load in MEM/WB supplies its memory data
        exF = makeFwd(1'b1, 1'b0, 3'd2, 16'h4444, 16'h0);
        memF = makeFwd(1'b1, 1'b1, 3'd5, 16'h5555, 16'h0777);
        issue(1'b1, w, 16'haaaa, 16'h0101, exF, memF);
        memF = makeFwd(1'b1, 1'b0, 3'd5, 16'h0123, 16'hdead);
        issue(1'b1, w, 16'haaaa, 16'h0101, exF, memF);
        // Non-writing and mismatched sources leave the register file in use
        exF = makeFwd(1'b0, 1'b0, 3'd3, 16'h6666, 16'h0);
        memF = makeFwd(1'b1, 1'b1, 3'd6, 16'h7777, 16'h8888);
        issue(1'b1, w, 16'haaaa, 16'h0101, exF, memF);
        // Register 0 forwards like any other
        exF = makeFwd(1'b1, 1'b0, 3'd0, 16'h00f0, 16'h0);
        w = rInstr(execPkg::ALU_ARITH, 3'd0, 3'd0, 3'd7, 2'b00);
        issue(1'b1, w, 16'h1234, 16'h4321, exF, noFwd);
        for (int i = 0; i < 12; i++) begin
            exF = makeFwd(1'($urandom), 1'b0, 3'($urandom), 16'($urandom), 16'($urandom));
            memF = makeFwd(1'($urandom), 1'($urandom), 3'($urandom), 16'($urandom),
                           16'($urandom));
            w = rInstr(execPkg::ALU_ARITH, 3'($urandom), 3'($urandom), 3'($urandom),
                       2'(i));
            issue(1'b1, w, 16'($urandom), 16'($urandom), exF, memF);
        end
        idleCycle();
        endTest("operand forwarding");
    endtask

    task automatic testErrIdle();
        sendR(execPkg::ALU_ARITH, 2'b00, 16'h7fff, 16'h0001);
        sendR(execPkg::ALU_ARITH, 2'b00, 16'h8000, 16'hffff);
        sendR(execPkg::ALU_ARITH, 2'b00, 16'h0001, 16'h0002);
        sendR(execPkg::ALU_ARITH, 2'b01, 16'h0001, 16'h8000);
        sendR(execPkg::ALU_ARITH, 2'b01, 16'h8000, 16'h0000);
        sendI1(execPkg::ADDI, 5'h01, 16'h7fff);
        sendI1(execPkg::SUBI, 5'h00, 16'h8000);
        sendR(execPkg::ALU_ARITH, 2'b10, 16'h7fff, 16'h8001);
        // The difference overflows here but set instructions raise no error
        sendR(execPkg::SLT, 2'b00, 16'h7fff, 16'hffff);
        issue(1'b0, rInstr(execPkg::ALU_ARITH, 3'd1, 3'd2, 3'd3, 2'b00), 16'h7fff,
              16'h0001, noFwd, noFwd);
        idleCycle();
        for (int i = 0; i < 10; i++) begin
            sendR(execPkg::ALU_ARITH, 2'(i % 2), 16'($urandom), 16'($urandom));
        end
        idleCycle();
        endTest("overflow error and idle cycles");
    endtask

    initial begin
        void'($urandom(32'h9e9b_b68a));
        pendLive = 1'b0;
        pendExp = '0;
        pendWord = '0;
        rst <= 1'b1;
        // A valid overflowing add sits on the inputs for the whole reset
        inValid <= 1'b1;
        instr <= rInstr(execPkg::ALU_ARITH, 3'd1, 3'd2, 3'd3, 2'b00);
        rsData <= 16'h7fff;
        rtData <= 16'h0001;
        exMemFwd <= noFwd;
        memWbFwd <= noFwd;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        inValid <= 1'b0;

        testResetArith();
        testImmediates();
        testShifts();
        testSetMisc();
        testForwarding();
        testErrIdle();

        $display("Tests run: %0d, errors: %0d", testCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
